//--- Bender.yml
package:
  name: sc_datapath

sources:
  - files:
      - src/cpu_types_pkg.sv
      - src/fetch.sv
      - src/scoreboard.sv
      - src/regfile.sv
      - src/execute.sv
      - src/sc_datapath.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/sc_datapath_assert.sv
      - testbench/sc_datapath_tb.sv

//--- sc_datapath.f
src/cpu_types_pkg.sv
src/fetch.sv
src/scoreboard.sv
src/regfile.sv
src/execute.sv
src/sc_datapath.sv
testbench/tb_clock_gen.sv
testbench/sc_datapath_assert.sv
testbench/sc_datapath_tb.sv

//--- src/cpu_types_pkg.sv
// CPU shared types
package cpu_types_pkg;

    // Datapath widths
    localparam int word_w = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs = 32;

    typedef logic [word_w-1:0] word_t;
    typedef logic [reg_addr_w-1:0] regbits_t;

    // RV32I major opcodes in use
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_t;

    // All ones stops the core
    localparam word_t halt_word = 32'hffff_ffff;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } aluop_t;

    // Instruction formats, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        regbits_t   rs2;
        regbits_t   rs1;
        logic [2:0] funct3;
        regbits_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        regbits_t    rs1;
        logic [2:0]  funct3;
        regbits_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        regbits_t   rs2;
        regbits_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    // Branch offset bits are scattered
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        regbits_t   rs2;
        regbits_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    // One word, four views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_u;

    // Fetch to dispatch latch
    typedef struct packed {
        logic   valid;
        instr_u instr;
        word_t  pc;
    } fd_t;

    // Issue to execute latch
    typedef struct packed {
        logic   valid;
        instr_u instr;
        word_t  pc;
        word_t  rdat1;
        word_t  rdat2;
    } ie_t;

    // Execute to writeback latch
    typedef struct packed {
        logic     valid;
        logic     wen;
        regbits_t wsel;
        word_t    wdat;
    } ew_t;

    // Data memory request
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t store;
    } dmem_req_t;

endpackage

//--- src/execute.sv
// Execute stage
module execute (
    input  logic                     CLK,
    input  logic                     nrst,
    input  cpu_types_pkg::ie_t       ie,
    input  logic                     dhit,
    input  cpu_types_pkg::word_t     dmemload,
    output cpu_types_pkg::dmem_req_t dmem,
    output logic                     busy,
    output logic                     redirect,
    output cpu_types_pkg::word_t     redirect_pc,
    output cpu_types_pkg::ew_t       ew
);
    cpu_types_pkg::opcode_t opc;
    cpu_types_pkg::aluop_t aluop;
    cpu_types_pkg::word_t imm_i;
    cpu_types_pkg::word_t imm_s;
    cpu_types_pkg::word_t imm_b;
    cpu_types_pkg::word_t port_b;
    cpu_types_pkg::word_t alu_out;
    cpu_types_pkg::dmem_req_t mem_req;
    cpu_types_pkg::regbits_t mem_rd;
    logic is_alu;
    logic is_mem;
    logic mem_pend;

    assign opc = ie.instr.r_fmt.opcode;
    assign is_alu = (opc == cpu_types_pkg::op_r) || (opc == cpu_types_pkg::op_imm);
    assign is_mem = ie.valid && ((opc == cpu_types_pkg::op_load)
                 || (opc == cpu_types_pkg::op_store));

    // Immediates, sign extended
    assign imm_i = {{20{ie.instr.i_fmt.imm[11]}}, ie.instr.i_fmt.imm};
    assign imm_s = {{20{ie.instr.s_fmt.imm_hi[6]}}, ie.instr.s_fmt.imm_hi,
                    ie.instr.s_fmt.imm_lo};
    assign imm_b = {{19{ie.instr.b_fmt.imm12}}, ie.instr.b_fmt.imm12, ie.instr.b_fmt.imm11,
                    ie.instr.b_fmt.imm10_5, ie.instr.b_fmt.imm4_1, 1'b0};

    // ALU op from funct3, funct7 bit 5 selects SUB on register ops
    always_comb begin
        aluop = cpu_types_pkg::alu_add;
        if (opc == cpu_types_pkg::op_r) begin
            case (ie.instr.r_fmt.funct3)
                3'b000: aluop = ie.instr.r_fmt.funct7[5] ? cpu_types_pkg::alu_sub
                                                         : cpu_types_pkg::alu_add;
                3'b100: aluop = cpu_types_pkg::alu_xor;
                3'b110: aluop = cpu_types_pkg::alu_or;
                3'b111: aluop = cpu_types_pkg::alu_and;
                default: ;
            endcase
        end else if (opc == cpu_types_pkg::op_imm) begin
            case (ie.instr.i_fmt.funct3)
                3'b100: aluop = cpu_types_pkg::alu_xor;
                3'b110: aluop = cpu_types_pkg::alu_or;
                3'b111: aluop = cpu_types_pkg::alu_and;
                default: ;
            endcase
        end
    end

    assign port_b = (opc == cpu_types_pkg::op_r) ? ie.rdat2 : imm_i;

    always_comb begin
        case (aluop)
            cpu_types_pkg::alu_sub: alu_out = ie.rdat1 - port_b;
            cpu_types_pkg::alu_and: alu_out = ie.rdat1 & port_b;
            cpu_types_pkg::alu_or:  alu_out = ie.rdat1 | port_b;
            cpu_types_pkg::alu_xor: alu_out = ie.rdat1 ^ port_b;
            default:                alu_out = ie.rdat1 + port_b;
        endcase
    end

    // BEQ on funct3 000, BNE on 001
    assign redirect = ie.valid && (opc == cpu_types_pkg::op_branch)
                   && ((ie.rdat1 == ie.rdat2) ^ ie.instr.b_fmt.funct3[0]);
    assign redirect_pc = ie.pc + imm_b;

    // Memory op parked here until dhit
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            mem_req <= '0;
        end else if (is_mem) begin
            mem_req.ren <= (opc == cpu_types_pkg::op_load);
            mem_req.wen <= (opc == cpu_types_pkg::op_store);
            mem_req.addr <= ie.rdat1 + ((opc == cpu_types_pkg::op_load) ? imm_i : imm_s);
            mem_req.store <= ie.rdat2;
        end else if (mem_pend && dhit) begin
            mem_req.ren <= 1'b0;
            mem_req.wen <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (is_mem) begin
            mem_rd <= ie.instr.i_fmt.rd;
        end
    end

    assign mem_pend = mem_req.ren || mem_req.wen;
    assign dmem = mem_req;
    assign busy = is_mem || (mem_pend && !dhit);

    // Writeback select, load data or ALU result
    always_comb begin
        ew = '0;
        if (mem_pend && dhit) begin
            ew.valid = 1'b1;
            ew.wen = mem_req.ren && (mem_rd != '0);
            ew.wsel = mem_rd;
            ew.wdat = dmemload;
        end else if (ie.valid && !is_mem) begin
            ew.valid = 1'b1;
            ew.wen = is_alu && (ie.instr.r_fmt.rd != '0);
            ew.wsel = ie.instr.r_fmt.rd;
            ew.wdat = alu_out;
        end
    end

endmodule

//--- src/fetch.sv
// Instruction fetch stage
module fetch (
    input  logic                 CLK,
    input  logic                 nrst,
    input  logic                 ihit,
    input  cpu_types_pkg::word_t imemload,
    input  logic                 stall,
    input  logic                 redirect,
    input  cpu_types_pkg::word_t redirect_pc,
    output cpu_types_pkg::word_t imemaddr,
    output cpu_types_pkg::fd_t   fd
);
    cpu_types_pkg::word_t pc;
    // Set once the halt word has been taken
    logic halted;
    logic take;

    // Word accepted this cycle
    assign take = ihit && !stall && !halted && !redirect;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc <= '0;
            halted <= 1'b0;
        end else if (redirect) begin
            // Taken branch restarts fetch at the target
            pc <= redirect_pc;
            halted <= 1'b0;
        end else if (take) begin
            pc <= pc + 32'd4;
            if (imemload == cpu_types_pkg::halt_word) begin
                halted <= 1'b1;
            end
        end
    end

    assign imemaddr = pc;

    // Pending word dropped on redirect
    assign fd.valid = ihit && !halted && !redirect;
    assign fd.instr = cpu_types_pkg::instr_u'(imemload);
    assign fd.pc = pc;

endmodule

//--- src/regfile.sv
// Register file
module regfile (
    input  logic                    CLK,
    input  logic                    nrst,
    input  logic                    wen,
    input  cpu_types_pkg::regbits_t wsel,
    input  cpu_types_pkg::word_t    wdat,
    input  cpu_types_pkg::regbits_t rsel1,
    input  cpu_types_pkg::regbits_t rsel2,
    output cpu_types_pkg::word_t    rdat1,
    output cpu_types_pkg::word_t    rdat2
);
    cpu_types_pkg::word_t regs [cpu_types_pkg::num_regs];
    logic wr_live;

    // x0 writes are dropped
    assign wr_live = wen && (wsel != '0);

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            regs <= '{default: '0};
        end else if (wr_live) begin
            regs[wsel] <= wdat;
        end
    end

    // Bypass the value being written
    assign rdat1 = (wr_live && wsel == rsel1) ? wdat : regs[rsel1];
    assign rdat2 = (wr_live && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

//--- src/sc_datapath.sv
// Scalar CPU datapath top
module sc_datapath (
    input  logic                 CLK,
    input  logic                 nrst,
    input  logic                 ihit,
    input  cpu_types_pkg::word_t imemload,
    output cpu_types_pkg::word_t imemaddr,
    input  logic                 dhit,
    input  cpu_types_pkg::word_t dmemload,
    output logic                 dmemren,
    output logic                 dmemwen,
    output cpu_types_pkg::word_t dmemaddr,
    output cpu_types_pkg::word_t dmemstore,
    output logic                 halt
);
    // Pipeline latches
    cpu_types_pkg::fd_t fd_fetch;
    cpu_types_pkg::fd_t fd_dispatch;
    cpu_types_pkg::ie_t ie_issue;
    cpu_types_pkg::ie_t ie_execute;
    cpu_types_pkg::ew_t ew_execute;
    cpu_types_pkg::ew_t ew_writeback;

    cpu_types_pkg::dmem_req_t dmem;
    cpu_types_pkg::regbits_t rsel1;
    cpu_types_pkg::regbits_t rsel2;
    cpu_types_pkg::word_t rdat1;
    cpu_types_pkg::word_t rdat2;
    cpu_types_pkg::word_t redirect_pc;
    logic dispatch;
    logic ex_busy;
    logic redirect;
    logic fd_stall;

    // Dispatch latch full and not draining
    assign fd_stall = fd_dispatch.valid && !dispatch;

    fetch FETCH (
        .CLK         (CLK),
        .nrst        (nrst),
        .ihit        (ihit),
        .imemload    (imemload),
        .stall       (fd_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imemaddr    (imemaddr),
        .fd          (fd_fetch)
    );

    scoreboard SCOREBOARD (
        .CLK      (CLK),
        .nrst     (nrst),
        .fd       (fd_dispatch),
        .ex_busy  (ex_busy),
        .redirect (redirect),
        .wb       (ew_writeback),
        .rsel1    (rsel1),
        .rsel2    (rsel2),
        .dispatch (dispatch),
        .halt     (halt)
    );

    regfile REGFILE (
        .CLK   (CLK),
        .nrst  (nrst),
        .wen   (ew_writeback.valid && ew_writeback.wen),
        .wsel  (ew_writeback.wsel),
        .wdat  (ew_writeback.wdat),
        .rsel1 (rsel1),
        .rsel2 (rsel2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    // Operands join the dispatched word
    assign ie_issue.valid = fd_dispatch.valid;
    assign ie_issue.instr = fd_dispatch.instr;
    assign ie_issue.pc = fd_dispatch.pc;
    assign ie_issue.rdat1 = rdat1;
    assign ie_issue.rdat2 = rdat2;

    execute EXECUTE (
        .CLK         (CLK),
        .nrst        (nrst),
        .ie          (ie_execute),
        .dhit        (dhit),
        .dmemload    (dmemload),
        .dmem        (dmem),
        .busy        (ex_busy),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ew          (ew_execute)
    );

    assign dmemren = dmem.ren;
    assign dmemwen = dmem.wen;
    assign dmemaddr = dmem.addr;
    assign dmemstore = dmem.store;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            fd_dispatch <= '0;
            ie_execute <= '0;
            ew_writeback <= '0;
        end else begin
            // Taken branch squashes the word behind it
            if (redirect) begin
                fd_dispatch.valid <= 1'b0;
            end else if (!fd_stall) begin
                fd_dispatch <= fd_fetch;
            end
            // Bubble unless something dispatched
            ie_execute <= dispatch ? ie_issue : '0;
            ew_writeback <= ew_execute;
        end
    end

endmodule

//--- src/scoreboard.sv
// Scoreboard with dispatch control
module scoreboard (
    input  logic                    CLK,
    input  logic                    nrst,
    input  cpu_types_pkg::fd_t      fd,
    input  logic                    ex_busy,
    input  logic                    redirect,
    input  cpu_types_pkg::ew_t      wb,
    output cpu_types_pkg::regbits_t rsel1,
    output cpu_types_pkg::regbits_t rsel2,
    output logic                    dispatch,
    output logic                    halt
);
    // One pending-write bit per register
    logic [cpu_types_pkg::num_regs-1:0] busy;
    logic [cpu_types_pkg::num_regs-1:0] busy_eff;
    logic [cpu_types_pkg::num_regs-1:0] set_mask;
    logic [cpu_types_pkg::num_regs-1:0] clr_mask;
    cpu_types_pkg::opcode_t opc;
    cpu_types_pkg::regbits_t rd;
    logic uses_rs1;
    logic uses_rs2;
    logic writes_rd;
    logic is_halt;
    logic hazard;

    // Register fields sit in the same place in every format
    assign opc = fd.instr.r_fmt.opcode;
    assign rsel1 = fd.instr.r_fmt.rs1;
    assign rsel2 = fd.instr.r_fmt.rs2;
    assign rd = fd.instr.r_fmt.rd;
    assign is_halt = (cpu_types_pkg::word_t'(fd.instr) == cpu_types_pkg::halt_word);

    always_comb begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        writes_rd = 1'b0;
        case (opc)
            cpu_types_pkg::op_r: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                writes_rd = 1'b1;
            end
            cpu_types_pkg::op_imm, cpu_types_pkg::op_load: begin
                uses_rs1 = 1'b1;
                writes_rd = 1'b1;
            end
            cpu_types_pkg::op_store, cpu_types_pkg::op_branch: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            default: ;
        endcase
        // x0 never tracked
        if (rd == '0) begin
            writes_rd = 1'b0;
        end
    end

    // Writeback this cycle frees the register, read sees it via write-through
    always_comb begin
        clr_mask = '0;
        clr_mask[wb.wsel] = wb.valid && wb.wen;
        set_mask = '0;
        set_mask[rd] = dispatch && writes_rd;
    end

    assign busy_eff = busy & ~clr_mask;
    assign hazard = (uses_rs1 && busy_eff[rsel1]) || (uses_rs2 && busy_eff[rsel2])
                 || (writes_rd && busy_eff[rd]);
    assign dispatch = fd.valid && !hazard && !ex_busy && !halt && !redirect;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy <= '0;
            halt <= 1'b0;
        end else begin
            // New writer wins over a same-cycle clear
            busy <= busy_eff | set_mask;
            if (dispatch && is_halt) begin
                halt <= 1'b1;
            end
        end
    end

endmodule

//--- testbench/sc_datapath_assert.sv
// Datapath port assertions
module sc_datapath_assert (
    input logic                 CLK,
    input logic                 nrst,
    input logic                 dhit,
    input logic                 dmemren,
    input logic                 dmemwen,
    input cpu_types_pkg::word_t dmemaddr,
    input cpu_types_pkg::word_t dmemstore,
    input cpu_types_pkg::word_t imemaddr,
    input logic                 halt
);
    timeunit 1ns;
    timeprecision 100ps;

    // Count of failed assertions
    int fail_count = 0;

    // Read and write strobes are exclusive
    no_dual_access: assert property (@(posedge CLK) disable iff (!nrst)
        !(dmemren && dmemwen))
    else begin
        $error("dmemren and dmemwen high together");
        fail_count++;
    end

    // Request held until dhit
    req_held: assert property (@(posedge CLK) disable iff (!nrst)
        (dmemren || dmemwen) && !dhit |=> $stable(dmemren) && $stable(dmemwen)
        && $stable(dmemaddr) && $stable(dmemstore))
    else begin
        $error("data request changed before dhit");
        fail_count++;
    end

    // Halt is sticky
    halt_sticky: assert property (@(posedge CLK) disable iff (!nrst) halt |=> halt)
    else begin
        $error("halt fell after being set");
        fail_count++;
    end

    fetch_aligned: assert property (@(posedge CLK) disable iff (!nrst)
        imemaddr[1:0] == 2'b00)
    else begin
        $error("imemaddr not word aligned");
        fail_count++;
    end

endmodule

//--- testbench/sc_datapath_stimulus.txt
// Program words from word 0; from word 0x100 records of test number,
// store address and store data, ended by a zero test number
@000
// 1 ALU ops on x1 = 0x123 and x2 = 0xf0, stores at 0x100 to 0x114
12300093 0f000113 002081b3 40208233 0020f2b3 0020e333 0020c3b3 401104b3
10302023 10402223 10502423 10602623 10702823 10902a23
// 2 x10 doubled twice then plus 3, x11 = x10 ^ x2
00100513 00a50533 00a50533 00350513 002545b3 12a02023 12b02223
// 3 store and reload 0x55, load-use add, reload of 0x100 doubled
05500613 14c02023 14002683 00168713 14e02223 10002783 00f78833 15002423
// 4 branches, stores to 0x160 0x164 0x170 sit on skipped paths
00500893 00500913 07700993 01288663 17302023 17302223 01289463 17102423
01388463 17302623 01389463 17302823 17202a23
// 5 writes to x0, then x0 stored
3ab00013 00208033 18002023
// 6 halt word, the store behind it never runs
ffffffff 1c102023
@100
// test address data
1 00000100 00000213
1 00000104 00000033
1 00000108 00000020
1 0000010c 000001f3
1 00000110 000001d3
1 00000114 ffffffcd
2 00000120 00000007
2 00000124 000000f7
3 00000140 00000055
3 00000144 00000056
3 00000148 00000426
4 00000168 00000005
4 0000016c 00000077
4 00000174 00000005
5 00000180 00000000
0

//--- testbench/sc_datapath_tb.sv
// Scalar datapath testbench
module sc_datapath_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int stim_depth = 512;
    localparam int rec_base = 256;
    localparam int mem_depth = 256;
    localparam int num_store_tests = 5;
    localparam int reset_limit = 64;
    localparam int store_limit = 3000;
    localparam int halt_limit = 3000;
    localparam int quiet_cycles = 200;

    logic CLK;
    logic nrst;
    logic ihit = 1'b0;
    logic dhit = 1'b0;
    logic dmemren;
    logic dmemwen;
    logic halt;
    cpu_types_pkg::word_t imemload;
    cpu_types_pkg::word_t imemaddr;
    cpu_types_pkg::word_t dmemload;
    cpu_types_pkg::word_t dmemaddr;
    cpu_types_pkg::word_t dmemstore;

    cpu_types_pkg::word_t stim [stim_depth];
    cpu_types_pkg::word_t imem [mem_depth];
    cpu_types_pkg::word_t dmem [mem_depth];

    // Expected stores, oldest first
    cpu_types_pkg::word_t exp_addr [$];
    cpu_types_pkg::word_t exp_data [$];
    // Running store count at the end of each test
    int stores_upto [num_store_tests+1];

    integer seed = 32'hbc7d;
    int errors = 0;
    int stores_seen = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    tb_clock_gen CLKGEN (
        .CLK  (CLK),
        .nrst (nrst)
    );

    sc_datapath DUT (
        .CLK       (CLK),
        .nrst      (nrst),
        .ihit      (ihit),
        .imemload  (imemload),
        .imemaddr  (imemaddr),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .dmemren   (dmemren),
        .dmemwen   (dmemwen),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .halt      (halt)
    );

    bind sc_datapath sc_datapath_assert ASSERT (
        .CLK       (CLK),
        .nrst      (nrst),
        .dhit      (dhit),
        .dmemren   (dmemren),
        .dmemwen   (dmemwen),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .imemaddr  (imemaddr),
        .halt      (halt)
    );

    // Asynchronous read ports, word indexed
    assign imemload = imem[imemaddr[9:2]];
    // Junk on the data port unless a read is requested
    assign dmemload = dmemren ? dmem[dmemaddr[9:2]] : 32'hbad0_bad0;

    // Ready strobes, ihit mostly high and dhit sparse
    always @(posedge CLK) begin
        ihit <= ($random(seed) & 3) != 0;
        dhit <= ($random(seed) & 3) == 0;
        // Store lands on the edge that ends its dhit cycle
        if (nrst && dmemwen && dhit) begin
            dmem[dmemaddr[9:2]] <= dmemstore;
        end
    end

    // Store completes in the dhit cycle
    always @(negedge CLK) begin
        if (nrst && dmemwen && dhit) begin
            match_store(dmemaddr, dmemstore);
        end
    end

    task automatic check_value(input string name, input cpu_types_pkg::word_t got,
                               input cpu_types_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic match_store(input cpu_types_pkg::word_t addr,
                               input cpu_types_pkg::word_t data);
        if (exp_addr.size() == 0) begin
            $display("unexpected store of %h to %h after the last expected one", data, addr);
            errors++;
        end else begin
            check_value("dmemaddr", addr, exp_addr.pop_front());
            check_value("dmemstore", data, exp_data.pop_front());
        end
        stores_seen++;
    endtask

    function automatic string test_label(input int t);
        case (t)
            1: return "alu register ops";
            2: return "dependent chain";
            3: return "store load round trip";
            4: return "branch taken and not taken";
            5: return "x0 stays zero";
            default: return "halt";
        endcase
    endfunction

    task automatic load_stimulus();
        int i;
        int t;
        int per_test [num_store_tests+1];
        $readmemh("testbench/sc_datapath_stimulus.txt", stim);
        for (i = 0; i < mem_depth; i++) begin
            imem[i] = stim[i];
            // Pattern from the byte address
            dmem[i] = 32'hd00d_0000 ^ (i << 2);
        end
        per_test = '{default: 0};
        // Records are test, address, data until a zero test number
        i = rec_base;
        while (i + 2 < stim_depth && !$isunknown(stim[i]) && stim[i] != '0) begin
            t = stim[i];
            if (t < 1 || t > num_store_tests) begin
                $display("stimulus record at word %0d names unknown test %0d", i, t);
                errors++;
            end else begin
                per_test[t]++;
                exp_addr.push_back(stim[i+1]);
                exp_data.push_back(stim[i+2]);
            end
            i += 3;
        end
        stores_upto[0] = 0;
        for (t = 1; t <= num_store_tests; t++) begin
            stores_upto[t] = stores_upto[t-1] + per_test[t];
        end
        if (exp_addr.size() == 0) begin
            $display("no expected stores were read from the stimulus file");
            errors++;
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (nrst !== 1'b1 && cycles < reset_limit) begin
            @(negedge CLK);
            cycles++;
        end
        if (nrst !== 1'b1) begin
            $display("timed out waiting for reset to be released");
            errors++;
        end
    endtask

    task automatic log_result(input int t, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %0d %s: pass", t, test_label(t));
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", t, test_label(t),
                     errors - err_before);
        end
    endtask

    task automatic run_store_test(input int t);
        int cycles;
        int err_before;
        err_before = errors;
        cycles = 0;
        // Store count settles at the falling edge before this
        while (stores_seen < stores_upto[t] && cycles < store_limit) begin
            @(posedge CLK);
            cycles++;
        end
        if (stores_seen < stores_upto[t]) begin
            $display("test %0d timed out with %0d of %0d stores seen", t, stores_seen,
                     stores_upto[t]);
            errors++;
        end
        log_result(t, err_before);
    endtask

    task automatic run_halt_test();
        int cycles;
        int err_before;
        err_before = errors;
        cycles = 0;
        while (halt !== 1'b1 && cycles < halt_limit) begin
            @(negedge CLK);
            cycles++;
        end
        if (halt !== 1'b1) begin
            $display("timed out waiting for halt to rise");
            errors++;
        end
        // Any store in this window has no record left
        repeat (quiet_cycles) @(negedge CLK);
        check_value("halt", {31'b0, halt}, 32'd1);
        log_result(num_store_tests + 1, err_before);
    endtask

    task automatic report();
        int assert_fails;
        assert_fails = DUT.ASSERT.fail_count;
        if (assert_fails != 0) begin
            $display("%0d assertion failures during the run", assert_fails);
            errors += assert_fails;
        end
        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        int t;
        load_stimulus();
        wait_reset();
        for (t = 1; t <= num_store_tests; t++) begin
            run_store_test(t);
        end
        run_halt_test();
        report();
    end

endmodule

//--- testbench/tb_clock_gen.sv
// Clock and reset source
module tb_clock_gen (
    output logic CLK,
    output logic nrst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 8;

    // 4 ns period
    initial begin
        CLK = 1'b0;
        forever begin
            #2 CLK = ~CLK;
        end
    end

    // Reset low for the first cycles
    initial begin
        nrst = 1'b0;
        repeat (reset_cycles) @(posedge CLK);
        nrst <= 1'b1;
    end

endmodule
